//--- mach_pkg.sv
// machine package with the datapath widths, the word and flags types and the register index
`default_nettype none

package mach_pkg;

    // data and address share one width throughout the machine
    localparam int WORD_W = 12;

    // the flags word carries Z, N, C and V
    localparam int FLAGS_W = 4;

    // size of the architectural register file
    localparam int REG_COUNT = 4;

    // index width follows from the register count
    localparam int REG_IDX_W = $clog2(REG_COUNT);

    // one data or address word
    typedef logic [WORD_W-1:0] word_t;

    // flags word, bit positions live with the instruction set
    typedef logic [FLAGS_W-1:0] flags_t;

    // register index as found in the rd, rs and rt fields
    typedef logic [REG_IDX_W-1:0] reg_idx_t;

endpackage

`default_nettype wire

//--- isa_pkg.sv
// instruction set package with opcodes, condition codes, flag positions and the instruction word
`default_nettype none

package isa_pkg;

    // opcode sits in the top four bits of every instruction
    typedef logic [3:0] opcode_t;

    localparam opcode_t OPC_NOP    = 4'h0;
    localparam opcode_t OPC_R_ADD  = 4'h1;
    localparam opcode_t OPC_R_SUB  = 4'h2;
    localparam opcode_t OPC_R_AND  = 4'h3;
    localparam opcode_t OPC_R_OR   = 4'h4;
    localparam opcode_t OPC_I_ADDi = 4'h5;
    localparam opcode_t OPC_R_LD   = 4'h6;
    localparam opcode_t OPC_I_LDi  = 4'h7;
    localparam opcode_t OPC_R_ST   = 4'h8;
    localparam opcode_t OPC_I_STi  = 4'h9;
    localparam opcode_t OPC_R_BCC  = 4'ha;
    localparam opcode_t OPC_I_BCCi = 4'hb;

    // bit index of each flag inside mach_pkg::flags_t
    localparam int FLAG_Z = 0;
    localparam int FLAG_N = 1;
    localparam int FLAG_C = 2;
    localparam int FLAG_V = 3;

    // branch conditions, carried in the rd field of a branch
    localparam logic [1:0] COND_ALWAYS = 2'd0;
    localparam logic [1:0] COND_Z      = 2'd1;
    localparam logic [1:0] COND_N      = 2'd2;
    localparam logic [1:0] COND_C      = 2'd3;

    // width of the immediate in the I form
    localparam int IMM_W = 6;

    // register form with three register fields and two spare bits
    typedef struct packed {
        opcode_t            opcode;
        mach_pkg::reg_idx_t rd;
        mach_pkg::reg_idx_t rs;
        mach_pkg::reg_idx_t rt;
        logic [1:0]         spare;
    } instr_r_t;

    // immediate form with one register field and a six bit immediate
    typedef struct packed {
        opcode_t            opcode;
        mach_pkg::reg_idx_t rd;
        logic [IMM_W-1:0]   imm6;
    } instr_i_t;

    // the same word seen either way, opcode and rd line up in both
    typedef union packed {
        instr_r_t r;
        instr_i_t i;
    } instr_t;

    function automatic logic is_branch(opcode_t op);
        return (op == OPC_R_BCC) || (op == OPC_I_BCCi);
    endfunction

    function automatic logic is_mem(opcode_t op);
        return (op == OPC_R_LD) || (op == OPC_I_LDi) || (op == OPC_R_ST) || (op == OPC_I_STi);
    endfunction

    function automatic logic is_load(opcode_t op);
        return (op == OPC_R_LD) || (op == OPC_I_LDi);
    endfunction

    // ALU instructions and loads are the only ones with a destination
    function automatic logic writes_reg(opcode_t op);
        return (op == OPC_R_ADD) || (op == OPC_R_SUB) || (op == OPC_R_AND) ||
               (op == OPC_R_OR) || (op == OPC_I_ADDi) || is_load(op);
    endfunction

endpackage

`default_nettype wire

//--- reg_file.sv
// register file with two combinational read ports, one write port and write-through bypass
`timescale 1ns/10ps
`default_nettype none

module reg_file (
    input  logic               clk,
    input  logic               rst,
    input  mach_pkg::reg_idx_t ra_idx,
    input  mach_pkg::reg_idx_t rb_idx,
    input  logic               wb_en,
    input  mach_pkg::reg_idx_t wb_reg,
    input  mach_pkg::word_t    wb_data,
    output mach_pkg::word_t    ra_data,
    output mach_pkg::word_t    rb_data
);

    // architectural registers, all cleared by reset
    mach_pkg::word_t regs [mach_pkg::REG_COUNT];

    // the write lands at the end of the write-back cycle
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < mach_pkg::REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_en) begin
            regs[wb_reg] <= wb_data;
        end
    end

    // an instruction issued in the write-back cycle of its producer
    // must see the new value, so a matching index takes wb_data
    always_comb begin
        if (wb_en && (wb_reg == ra_idx)) begin
            ra_data = wb_data;
        end else begin
            ra_data = regs[ra_idx];
        end
    end

    always_comb begin
        if (wb_en && (wb_reg == rb_idx)) begin
            rb_data = wb_data;
        end else begin
            rb_data = regs[rb_idx];
        end
    end

endmodule

`default_nettype wire

//--- stage3ex.sv
// execute stage with operand selection, ALU, flags register, branch resolution and EX/MA latch
`timescale 1ns/10ps
`default_nettype none

module stage3ex (
    input  logic               clk,
    input  logic               rst,
    input  logic               issue_valid,
    input  mach_pkg::word_t    issue_pc,
    input  isa_pkg::instr_t    issue_instr,
    input  mach_pkg::word_t    ra_data,
    input  mach_pkg::word_t    rb_data,
    output mach_pkg::reg_idx_t ra_idx,
    output mach_pkg::reg_idx_t rb_idx,
    output logic               ex_valid,
    output mach_pkg::word_t    ex_pc,
    output isa_pkg::instr_t    ex_instr,
    output mach_pkg::word_t    ex_result,
    output mach_pkg::word_t    ex_store_data,
    output mach_pkg::flags_t   ex_flags
);

    localparam int W = mach_pkg::WORD_W;

    isa_pkg::opcode_t  opcode;
    mach_pkg::word_t   imm_sext;
    mach_pkg::word_t   imm_zext;
    mach_pkg::word_t   op_b;
    logic              is_sub;
    logic              alu_op;
    logic [W:0]        sum;
    mach_pkg::word_t   alu_res;
    logic              alu_c;
    logic              alu_v;
    mach_pkg::flags_t  alu_flags;
    logic              taken;
    mach_pkg::word_t   target;
    mach_pkg::word_t   result;

    // opcode and rd line up in both views of the word
    assign opcode = issue_instr.r.opcode;

    // the immediate only makes sense through the I view
    assign imm_sext = {{(W - isa_pkg::IMM_W){issue_instr.i.imm6[isa_pkg::IMM_W-1]}},
                       issue_instr.i.imm6};
    assign imm_zext = {{(W - isa_pkg::IMM_W){1'b0}}, issue_instr.i.imm6};

    // ADDi adds to its own destination, everything else reads rs on port a
    assign ra_idx = (opcode == isa_pkg::OPC_I_ADDi) ? issue_instr.i.rd : issue_instr.r.rs;

    // stores read the data register from rd, register ALU ops read rt
    assign rb_idx = ((opcode == isa_pkg::OPC_R_ST) || (opcode == isa_pkg::OPC_I_STi)) ?
                    issue_instr.r.rd : issue_instr.r.rt;

    // ALU instructions are the writers that are not loads
    assign alu_op = isa_pkg::writes_reg(opcode) && !isa_pkg::is_load(opcode);

    // one adder handles ADD, ADDi and SUB, subtraction adds the inverse plus one
    // so the carry out reads as not-borrow
    assign is_sub = (opcode == isa_pkg::OPC_R_SUB);
    assign op_b   = (opcode == isa_pkg::OPC_I_ADDi) ? imm_sext : (is_sub ? ~rb_data : rb_data);
    assign sum    = {1'b0, ra_data} + {1'b0, op_b} + {{W{1'b0}}, is_sub};

    always_comb begin
        alu_res = sum[W-1:0];
        alu_c   = sum[W];
        // overflow when both addends agree in sign and the sum does not
        alu_v   = (ra_data[W-1] == op_b[W-1]) && (sum[W-1] != ra_data[W-1]);
        if (opcode == isa_pkg::OPC_R_AND) begin
            alu_res = ra_data & rb_data;
            alu_c   = 1'b0;
            alu_v   = 1'b0;
        end else if (opcode == isa_pkg::OPC_R_OR) begin
            alu_res = ra_data | rb_data;
            alu_c   = 1'b0;
            alu_v   = 1'b0;
        end
    end

    always_comb begin
        alu_flags                 = '0;
        alu_flags[isa_pkg::FLAG_Z] = (alu_res == '0);
        alu_flags[isa_pkg::FLAG_N] = alu_res[W-1];
        alu_flags[isa_pkg::FLAG_C] = alu_c;
        alu_flags[isa_pkg::FLAG_V] = alu_v;
    end

    // the condition code lives in the rd field and tests the flags register
    always_comb begin
        case (issue_instr.r.rd)
            isa_pkg::COND_Z: taken = ex_flags[isa_pkg::FLAG_Z];
            isa_pkg::COND_N: taken = ex_flags[isa_pkg::FLAG_N];
            isa_pkg::COND_C: taken = ex_flags[isa_pkg::FLAG_C];
            default:         taken = 1'b1;
        endcase
    end

    // BCC jumps to a register, BCCi is relative to its own pc
    assign target = (opcode == isa_pkg::OPC_R_BCC) ? ra_data : issue_pc + imm_sext;

    // loads and stores carry their address as the result
    always_comb begin
        if (alu_op) begin
            result = alu_res;
        end else if ((opcode == isa_pkg::OPC_R_LD) || (opcode == isa_pkg::OPC_R_ST)) begin
            result = ra_data;
        end else if ((opcode == isa_pkg::OPC_I_LDi) || (opcode == isa_pkg::OPC_I_STi)) begin
            result = imm_zext;
        end else if (isa_pkg::is_branch(opcode)) begin
            result = taken ? target : issue_pc + 1'b1;
        end else begin
            result = '0;
        end
    end

    // ex_flags doubles as the flags register and only ALU ops change it
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ex_valid      <= 1'b0;
            ex_pc         <= '0;
            ex_instr      <= '0;
            ex_result     <= '0;
            ex_store_data <= '0;
            ex_flags      <= '0;
        end else begin
            ex_valid <= issue_valid;
            if (issue_valid) begin
                ex_pc         <= issue_pc;
                ex_instr      <= issue_instr;
                ex_result     <= result;
                ex_store_data <= rb_data;
                if (alu_op) begin
                    ex_flags <= alu_flags;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- stage4ma.sv
// memory-address stage that selects the retiring pc, drives the data address and holds MA/MO
`timescale 1ns/10ps
`default_nettype none

module stage4ma (
    input  logic             clk,
    input  logic             rst,
    input  logic             ex_valid,
    input  mach_pkg::word_t  ex_pc,
    input  isa_pkg::instr_t  ex_instr,
    input  mach_pkg::word_t  ex_result,
    input  mach_pkg::word_t  ex_store_data,
    input  mach_pkg::flags_t ex_flags,
    output logic             ma_valid,
    output mach_pkg::word_t  ma_pc,
    output isa_pkg::instr_t  ma_instr,
    output mach_pkg::word_t  ma_result,
    output mach_pkg::word_t  ma_store_data,
    output mach_pkg::flags_t ma_flags,
    output mach_pkg::word_t  mem_addr
);

    isa_pkg::opcode_t opcode;
    mach_pkg::word_t  stage_pc;

    assign opcode = ex_instr.r.opcode;

    // a branch retires with the pc it resolved to, everything else with its own
    assign stage_pc = isa_pkg::is_branch(opcode) ? ex_result : ex_pc;

    // execute already formed the address for loads and stores
    // other instructions park the address bus at zero
    assign mem_addr = isa_pkg::is_mem(opcode) ? ex_result : '0;

    // the valid bit always moves, the payload only with a valid instruction
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ma_valid      <= 1'b0;
            ma_pc         <= '0;
            ma_instr      <= '0;
            ma_result     <= '0;
            ma_store_data <= '0;
            ma_flags      <= '0;
        end else begin
            ma_valid <= ex_valid;
            if (ex_valid) begin
                ma_pc         <= stage_pc;
                ma_instr      <= ex_instr;
                ma_result     <= ex_result;
                ma_store_data <= ex_store_data;
                ma_flags      <= ex_flags;
            end
        end
    end

endmodule

`default_nettype wire

//--- stage5mo.sv
// memory-operate stage with data memory, load and store, and the retirement and write-back latch
`timescale 1ns/10ps
`default_nettype none

module stage5mo #(
    parameter int DMEM_DEPTH = 64
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               ma_valid,
    input  mach_pkg::word_t    ma_pc,
    input  isa_pkg::instr_t    ma_instr,
    input  mach_pkg::word_t    ma_result,
    input  mach_pkg::word_t    ma_store_data,
    input  mach_pkg::flags_t   ma_flags,
    input  mach_pkg::word_t    mem_addr,
    output logic               retire_valid,
    output mach_pkg::word_t    retire_pc,
    output isa_pkg::instr_t    retire_instr,
    output mach_pkg::word_t    retire_result,
    output mach_pkg::flags_t   retire_flags,
    output logic               wb_en,
    output mach_pkg::reg_idx_t wb_reg,
    output mach_pkg::word_t    wb_data
);

    // only the low address bits select a word, higher addresses wrap
    localparam int ADDR_W = $clog2(DMEM_DEPTH);

    if ((1 << ADDR_W) != DMEM_DEPTH) begin : g_depth_check
        $error("DMEM_DEPTH must be a power of two");
    end

    isa_pkg::opcode_t opcode;
    logic             do_load;
    logic             do_store;
    logic [ADDR_W-1:0] addr_q;

    mach_pkg::word_t dmem [DMEM_DEPTH];

    assign opcode   = ma_instr.r.opcode;
    assign do_load  = ma_valid && isa_pkg::is_load(opcode);
    assign do_store = ma_valid && isa_pkg::is_mem(opcode) && !isa_pkg::is_load(opcode);

    // mem_addr is presented while the instruction is still in MA, so the
    // address is captured alongside the MA/MO latch and used one cycle later
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            addr_q <= '0;
        end else begin
            addr_q <= mem_addr[ADDR_W-1:0];
        end
    end

    // synchronous write port
    always_ff @(posedge clk) begin
        if (do_store) begin
            dmem[addr_q] <= ma_store_data;
        end
    end

    // the load reads at the same edge that registers the write-back,
    // so wb_data is the memory word for loads and the result otherwise
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            retire_valid  <= 1'b0;
            retire_pc     <= '0;
            retire_instr  <= '0;
            retire_result <= '0;
            retire_flags  <= '0;
            wb_en         <= 1'b0;
            wb_reg        <= '0;
            wb_data       <= '0;
        end else begin
            retire_valid <= ma_valid;
            wb_en        <= ma_valid && isa_pkg::writes_reg(opcode);
            if (ma_valid) begin
                retire_pc     <= ma_pc;
                retire_instr  <= ma_instr;
                retire_result <= ma_result;
                retire_flags  <= ma_flags;
                wb_reg        <= ma_instr.i.rd;
                wb_data       <= do_load ? dmem[addr_q] : ma_result;
            end
        end
    end

endmodule

`default_nettype wire

//--- pipe_top.sv
// pipeline back end that joins execute, memory address, memory operate and the register file
`timescale 1ns/10ps
`default_nettype none

module pipe_top #(
    parameter int DMEM_DEPTH = 64
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               issue_valid,
    input  mach_pkg::word_t    issue_pc,
    input  isa_pkg::instr_t    issue_instr,
    output logic               retire_valid,
    output mach_pkg::word_t    retire_pc,
    output isa_pkg::instr_t    retire_instr,
    output mach_pkg::word_t    retire_result,
    output mach_pkg::flags_t   retire_flags,
    output logic               wb_en,
    output mach_pkg::reg_idx_t wb_reg,
    output mach_pkg::word_t    wb_data
);

    // register file read ports
    mach_pkg::reg_idx_t ra_idx;
    mach_pkg::reg_idx_t rb_idx;
    mach_pkg::word_t    ra_data;
    mach_pkg::word_t    rb_data;

    // EX/MA latch
    logic             ex_valid;
    mach_pkg::word_t  ex_pc;
    isa_pkg::instr_t  ex_instr;
    mach_pkg::word_t  ex_result;
    mach_pkg::word_t  ex_store_data;
    mach_pkg::flags_t ex_flags;

    // MA/MO latch and the data address
    logic             ma_valid;
    mach_pkg::word_t  ma_pc;
    isa_pkg::instr_t  ma_instr;
    mach_pkg::word_t  ma_result;
    mach_pkg::word_t  ma_store_data;
    mach_pkg::flags_t ma_flags;
    mach_pkg::word_t  mem_addr;

    // the write-back outputs also feed the register file
    reg_file i_reg_file (
        .clk(clk), .rst(rst),
        .ra_idx(ra_idx), .rb_idx(rb_idx),
        .wb_en(wb_en), .wb_reg(wb_reg), .wb_data(wb_data),
        .ra_data(ra_data), .rb_data(rb_data)
    );

    stage3ex i_stage3ex (
        .clk(clk), .rst(rst),
        .issue_valid(issue_valid), .issue_pc(issue_pc), .issue_instr(issue_instr),
        .ra_data(ra_data), .rb_data(rb_data),
        .ra_idx(ra_idx), .rb_idx(rb_idx),
        .ex_valid(ex_valid), .ex_pc(ex_pc), .ex_instr(ex_instr),
        .ex_result(ex_result), .ex_store_data(ex_store_data), .ex_flags(ex_flags)
    );

    stage4ma i_stage4ma (
        .clk(clk), .rst(rst),
        .ex_valid(ex_valid), .ex_pc(ex_pc), .ex_instr(ex_instr),
        .ex_result(ex_result), .ex_store_data(ex_store_data), .ex_flags(ex_flags),
        .ma_valid(ma_valid), .ma_pc(ma_pc), .ma_instr(ma_instr),
        .ma_result(ma_result), .ma_store_data(ma_store_data), .ma_flags(ma_flags),
        .mem_addr(mem_addr)
    );

    stage5mo #(
        .DMEM_DEPTH(DMEM_DEPTH)
    ) i_stage5mo (
        .clk(clk), .rst(rst),
        .ma_valid(ma_valid), .ma_pc(ma_pc), .ma_instr(ma_instr),
        .ma_result(ma_result), .ma_store_data(ma_store_data), .ma_flags(ma_flags),
        .mem_addr(mem_addr),
        .retire_valid(retire_valid), .retire_pc(retire_pc), .retire_instr(retire_instr),
        .retire_result(retire_result), .retire_flags(retire_flags),
        .wb_en(wb_en), .wb_reg(wb_reg), .wb_data(wb_data)
    );

endmodule

`default_nettype wire

//--- pipe_properties.sv
// concurrent checks on the retirement timing and write-back control of the pipeline top level
`timescale 1ns/10ps
`default_nettype none

module pipe_properties (
    input logic clk,
    input logic rst,
    input logic issue_valid,
    input logic retire_valid,
    input logic wb_en
);

    // number of property failures so far
    int fail_count = 0;

    // every issue retires exactly three cycles later and nothing else retires
    a_retire_latency: assert property (
        @(posedge clk) disable iff (rst)
        retire_valid == $past(issue_valid, 3)
    ) else begin
        fail_count++;
        $error("retire_valid does not follow issue_valid by three cycles");
    end

    // reset holds the retirement and write-back strobes low
    a_quiet_in_reset: assert property (
        @(posedge clk)
        rst |-> (!retire_valid && !wb_en)
    ) else begin
        fail_count++;
        $error("retire_valid or wb_en high during reset");
    end

    // a write-back only comes with a retiring instruction
    a_wb_with_retire: assert property (
        @(posedge clk) disable iff (rst)
        wb_en |-> retire_valid
    ) else begin
        fail_count++;
        $error("wb_en high without retire_valid");
    end

endmodule

bind pipe_top pipe_properties i_pipe_properties (
    .clk(clk),
    .rst(rst),
    .issue_valid(issue_valid),
    .retire_valid(retire_valid),
    .wb_en(wb_en)
);

`default_nettype wire

//--- tb_pipe.sv
// testbench for the pipeline back end with a reference model, random stimulus and retirement checks
`timescale 1ns/10ps
`default_nettype none

module tb_pipe;

    localparam int DMEM_DEPTH = 64;
    localparam int ADDR_W     = $clog2(DMEM_DEPTH);
    localparam int N_RANDOM   = 400;
    localparam int WAIT_LIMIT = 50;

    logic               clk;
    logic               rst;
    logic               issue_valid;
    mach_pkg::word_t    issue_pc;
    isa_pkg::instr_t    issue_instr;
    logic               retire_valid;
    mach_pkg::word_t    retire_pc;
    isa_pkg::instr_t    retire_instr;
    mach_pkg::word_t    retire_result;
    mach_pkg::flags_t   retire_flags;
    logic               wb_en;
    mach_pkg::reg_idx_t wb_reg;
    mach_pkg::word_t    wb_data;

    // reference model state, updated in issue order
    logic [11:0] m_regs [4];
    logic [3:0]  m_flags;
    logic [11:0] m_mem [DMEM_DEPTH];
    int          ready_at [4];
    int          tick;
    logic [11:0] pc_next;
    int unsigned rng_state;
    logic [54:0] head;

    // expected record is {wb_en, wb_reg, wb_data, retire_pc, instr, result, flags}
    logic [54:0] exp_q [$];

    pipe_top #(
        .DMEM_DEPTH(DMEM_DEPTH)
    ) i_pipe_top (
        .clk(clk), .rst(rst),
        .issue_valid(issue_valid), .issue_pc(issue_pc), .issue_instr(issue_instr),
        .retire_valid(retire_valid), .retire_pc(retire_pc), .retire_instr(retire_instr),
        .retire_result(retire_result), .retire_flags(retire_flags),
        .wb_en(wb_en), .wb_reg(wb_reg), .wb_data(wb_data)
    );

    always #4 clk = ~clk;

    function automatic int unsigned rand_next();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state >> 8;
    endfunction

    // branch condition tested against the flags before this instruction
    function automatic logic cond_holds(logic [1:0] c);
        case (c)
            isa_pkg::COND_Z: return m_flags[isa_pkg::FLAG_Z];
            isa_pkg::COND_N: return m_flags[isa_pkg::FLAG_N];
            isa_pkg::COND_C: return m_flags[isa_pkg::FLAG_C];
            default:         return 1'b1;
        endcase
    endfunction

    // registers an instruction reads, as a one-hot mask
    function automatic logic [3:0] source_regs(logic [11:0] w);
        logic [3:0] m;
        m = '0;
        case (w[11:8])
            isa_pkg::OPC_R_ADD, isa_pkg::OPC_R_SUB, isa_pkg::OPC_R_AND, isa_pkg::OPC_R_OR: begin
                m[w[5:4]] = 1'b1;
                m[w[3:2]] = 1'b1;
            end
            isa_pkg::OPC_I_ADDi, isa_pkg::OPC_I_STi: m[w[7:6]] = 1'b1;
            isa_pkg::OPC_R_LD, isa_pkg::OPC_R_BCC:   m[w[5:4]] = 1'b1;
            isa_pkg::OPC_R_ST: begin
                m[w[5:4]] = 1'b1;
                m[w[7:6]] = 1'b1;
            end
            default: m = '0;
        endcase
        return m;
    endfunction

    task automatic step();
        @(posedge clk);
        tick++;
    endtask

    task automatic compare(input string name, input logic [11:0] expv, input logic [11:0] actv);
        assert (expv == actv) else begin
            $display("mismatch %s expected %h actual %h", name, expv, actv);
            $display("RESULT: FAIL");
            $fatal(1);
        end
    endtask

    // applies one instruction to the model and queues what must retire
    task automatic model_issue(input logic [11:0] w, input logic [11:0] pc);
        logic [3:0]  op;
        logic [1:0]  rd;
        logic [1:0]  rs;
        logic [1:0]  rt;
        logic [11:0] a;
        logic [11:0] b;
        logic [11:0] res;
        logic [11:0] sext;
        logic [11:0] wdata;
        logic [11:0] rpc;
        logic [12:0] wide;
        logic        c;
        logic        v;
        logic        wen;
        logic        alu;
        op    = w[11:8];
        rd    = w[7:6];
        rs    = w[5:4];
        rt    = w[3:2];
        sext  = {{6{w[5]}}, w[5:0]};
        res   = '0;
        wdata = '0;
        rpc   = pc;
        wen   = 1'b0;
        alu   = 1'b0;
        c     = 1'b0;
        v     = 1'b0;
        case (op)
            isa_pkg::OPC_R_ADD, isa_pkg::OPC_I_ADDi: begin
                // ADDi accumulates into its own destination
                a    = (op == isa_pkg::OPC_I_ADDi) ? m_regs[rd] : m_regs[rs];
                b    = (op == isa_pkg::OPC_I_ADDi) ? sext : m_regs[rt];
                wide = {1'b0, a} + {1'b0, b};
                res  = wide[11:0];
                c    = wide[12];
                v    = (a[11] == b[11]) && (res[11] != a[11]);
                alu  = 1'b1;
            end
            isa_pkg::OPC_R_SUB: begin
                a   = m_regs[rs];
                b   = m_regs[rt];
                res = a - b;
                c   = (a >= b);
                v   = (a[11] != b[11]) && (res[11] != a[11]);
                alu = 1'b1;
            end
            isa_pkg::OPC_R_AND: begin
                res = m_regs[rs] & m_regs[rt];
                alu = 1'b1;
            end
            isa_pkg::OPC_R_OR: begin
                res = m_regs[rs] | m_regs[rt];
                alu = 1'b1;
            end
            isa_pkg::OPC_R_LD, isa_pkg::OPC_I_LDi: begin
                res   = (op == isa_pkg::OPC_R_LD) ? m_regs[rs] : {6'b0, w[5:0]};
                wen   = 1'b1;
                wdata = m_mem[res[ADDR_W-1:0]];
                m_regs[rd] = wdata;
            end
            isa_pkg::OPC_R_ST, isa_pkg::OPC_I_STi: begin
                res = (op == isa_pkg::OPC_R_ST) ? m_regs[rs] : {6'b0, w[5:0]};
                m_mem[res[ADDR_W-1:0]] = m_regs[rd];
            end
            isa_pkg::OPC_R_BCC: begin
                res = cond_holds(rd) ? m_regs[rs] : pc + 12'd1;
                rpc = res;
            end
            isa_pkg::OPC_I_BCCi: begin
                res = cond_holds(rd) ? pc + sext : pc + 12'd1;
                rpc = res;
            end
            default: res = '0;
        endcase
        if (alu) begin
            wen   = 1'b1;
            wdata = res;
            m_regs[rd] = res;
            m_flags[isa_pkg::FLAG_Z] = (res == 12'd0);
            m_flags[isa_pkg::FLAG_N] = res[11];
            m_flags[isa_pkg::FLAG_C] = c;
            m_flags[isa_pkg::FLAG_V] = v;
        end
        exp_q.push_back({wen, rd, wdata, rpc, w, res, m_flags});
    endtask

    // waits until every source register has reached its write-back cycle, then issues
    task automatic issue_word(input logic [11:0] w);
        int         need;
        int         guard;
        logic [3:0] src;
        src   = source_regs(w);
        need  = 0;
        guard = 0;
        for (int i = 0; i < 4; i++) begin
            if (src[i] && (ready_at[i] > need)) begin
                need = ready_at[i];
            end
        end
        while (tick < need) begin
            assert (guard < WAIT_LIMIT) else begin
                $display("operand never became ready for issue");
                $display("RESULT: FAIL");
                $fatal(1);
            end
            issue_valid <= 1'b0;
            step();
            guard++;
        end
        issue_valid <= 1'b1;
        issue_pc    <= pc_next;
        issue_instr <= w;
        model_issue(w, pc_next);
        if ((w[11:8] >= 4'h1) && (w[11:8] <= 4'h7)) begin
            ready_at[w[7:6]] = tick + 3;
        end
        pc_next = pc_next + 12'd1;
        step();
    endtask

    // outputs are registered, so the falling edge sees them settled
    always @(negedge clk) begin
        // a bound property that fired at the last rising edge ends the run here
        assert (i_pipe_top.i_pipe_properties.fail_count == 0) else begin
            $display("a bound timing or control property failed");
            $display("RESULT: FAIL");
            $fatal(1);
        end
        if (!rst && retire_valid) begin
            assert (exp_q.size() != 0) else begin
                $display("retirement seen with no instruction outstanding");
                $display("RESULT: FAIL");
                $fatal(1);
            end
            head = exp_q.pop_front();
            compare("retire_pc", head[39:28], retire_pc);
            compare("retire_instr", head[27:16], retire_instr);
            compare("retire_result", head[15:4], retire_result);
            compare("retire_flags", {8'b0, head[3:0]}, {8'b0, retire_flags});
            compare("wb_en", {11'b0, head[54]}, {11'b0, wb_en});
            if (head[54]) begin
                compare("wb_reg", {10'b0, head[53:52]}, {10'b0, wb_reg});
                compare("wb_data", head[51:40], wb_data);
            end
        end
    end

    initial begin
        int guard;
        clk         = 1'b0;
        rst         = 1'b1;
        issue_valid = 1'b0;
        issue_pc    = '0;
        issue_instr = '0;
        rng_state   = 79;
        tick        = 0;
        pc_next     = 12'h100;
        m_flags     = '0;
        for (int i = 0; i < 4; i++) begin
            m_regs[i]   = '0;
            ready_at[i] = 0;
        end
        repeat (3) step();
        rst <= 1'b0;
        // quiet period, any retirement here has nothing queued and fails
        repeat (5) begin
            issue_valid <= 1'b0;
            step();
        end
        // fill the whole data memory, each STi right behind its ADDi uses the bypass
        for (int a = 0; a < DMEM_DEPTH; a++) begin
            issue_word({isa_pkg::OPC_I_ADDi, 2'(a % 4), 6'(rand_next())});
            issue_word({isa_pkg::OPC_I_STi, 2'(a % 4), 6'(a)});
        end
        for (int n = 0; n < N_RANDOM; n++) begin
            issue_word({4'(rand_next() % 12), 8'(rand_next())});
        end
        guard = 0;
        while ((exp_q.size() != 0) && (guard < WAIT_LIMIT)) begin
            issue_valid <= 1'b0;
            step();
            guard++;
        end
        if (exp_q.size() == 0) begin
            $display("RESULT: PASS");
            $finish;
        end else begin
            $display("timed out waiting for outstanding retirements");
            $display("RESULT: FAIL");
            $fatal(1);
        end
    end

endmodule

`default_nettype wire

//--- sim.f
mach_pkg.sv
isa_pkg.sv
reg_file.sv
stage3ex.sv
stage4ma.sv
stage5mo.sv
pipe_top.sv
pipe_properties.sv
tb_pipe.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_pipe
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "RESULT: PASS" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
